// ==== src/pq_macros.svh ====
//////////////////////////////////////////////////
// Sizing macros for the paged packet queue
// Include before any package or module that sizes storage
//////////////////////////////////////////////////

`ifndef PQ_MACROS_SVH
`define PQ_MACROS_SVH

// Number of pages in the page RAM
`define PQ_NUM_PAGES 16

// Words per page, also the longest packet
`define PQ_PAGE_WORDS 8

// Width of one stream data word
`define PQ_DATA_W 32

`endif

// ==== src/pq_mem_pkg.sv ====
//////////////////////////////////////////////////
// Storage widths shared by the queue blocks
//////////////////////////////////////////////////

`include "pq_macros.svh"

package pq_mem_pkg;

    //////////////////////////////////////////////////
    // Page and word addressing

    // Page number inside the page RAM
    typedef logic [$clog2(`PQ_NUM_PAGES)-1:0] page_idx_t;

    // Word offset inside one page
    typedef logic [$clog2(`PQ_PAGE_WORDS)-1:0] word_idx_t;

    // Packet length 1..PAGE_WORDS, needs one extra bit
    typedef logic [$clog2(`PQ_PAGE_WORDS):0] pkt_len_t;

    //////////////////////////////////////////////////
    // Payload and counts

    typedef logic [`PQ_DATA_W-1:0] data_word_t;

    // Free page count 0..NUM_PAGES, also used for wrap-bit pointers
    typedef logic [$clog2(`PQ_NUM_PAGES):0] page_cnt_t;

endpackage

// ==== src/pq_ctrl_pkg.sv ====
//////////////////////////////////////////////////
// Stream beats, packet descriptors and FSM states
//////////////////////////////////////////////////

`include "pq_macros.svh"

package pq_ctrl_pkg;

    //////////////////////////////////////////////////
    // Bundles

    // One word on the input or output stream
    typedef struct packed {
        pq_mem_pkg::data_word_t data;
        logic                   last;
    } beat_t;

    // Committed packet, one per filled page
    typedef struct packed {
        pq_mem_pkg::page_idx_t page;
        pq_mem_pkg::pkt_len_t  len;
    } pkt_desc_t;

    //////////////////////////////////////////////////
    // State machines

    // Free list loads its indices first
    typedef enum logic {FPL_INIT, FPL_ACTIVE} fpl_state_t;

    typedef enum logic [1:0] {ENQ_IDLE, ENQ_ALLOC, ENQ_WRITE, ENQ_ACK_WAIT} enq_state_t;

    typedef enum logic [2:0] {DEQ_IDLE, DEQ_READ, DEQ_OFFER, DEQ_FREE, DEQ_DONE} deq_state_t;

endpackage

// ==== src/pq_free_page_list.sv ====
//////////////////////////////////////////////////
// FIFO of free page indices with four-phase allocate and free
// Sweeps every index in after reset, then serves requests
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pq_macros.svh"

module pq_free_page_list (
    input  logic                  malloc,
    input  logic                  rst,
    input  logic                  alloc_req,
    output logic                  alloc_ack,
    output pq_mem_pkg::page_idx_t alloc_page,
    input  logic                  free_req,
    input  pq_mem_pkg::page_idx_t free_page,
    output logic                  free_ack,
    output pq_mem_pkg::page_cnt_t free_count
);

    import pq_mem_pkg::*;
    import pq_ctrl_pkg::*;

    //////////////////////////////////////////////////
    // Declarations

    page_idx_t  fifo [`PQ_NUM_PAGES];

    // Top bit tells full from empty
    page_cnt_t  wr_ptr;
    page_cnt_t  rd_ptr;

    fpl_state_t state;
    logic       empty;
    logic       alloc_take;
    logic       free_take;
    logic       fifo_we;
    page_idx_t  fifo_wdata;

    //////////////////////////////////////////////////
    // Responder conditions

    assign empty = (wr_ptr == rd_ptr);

    // New request seen while ack is still low
    assign alloc_take = (state == FPL_ACTIVE) && alloc_req && !alloc_ack && !empty;
    assign free_take  = (state == FPL_ACTIVE) && free_req && !free_ack;

    // Init sweep writes the index equal to the slot
    assign fifo_we    = (state == FPL_INIT) || free_take;
    assign fifo_wdata = (state == FPL_INIT) ? page_idx_t'(wr_ptr) : free_page;

    //////////////////////////////////////////////////
    // Control

    always_ff @(posedge malloc) begin
        if (rst) begin
            state      <= FPL_INIT;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            alloc_ack  <= 1'b0;
            free_ack   <= 1'b0;
            free_count <= '0;
        end else begin
            case (state)
                FPL_INIT: begin
                    // One index per cycle
                    wr_ptr <= wr_ptr + page_cnt_t'(1);
                    if (wr_ptr == page_cnt_t'(`PQ_NUM_PAGES - 1)) begin
                        state <= FPL_ACTIVE;
                    end
                end
                FPL_ACTIVE: begin
                    // Allocate responder
                    if (alloc_take) begin
                        alloc_ack <= 1'b1;
                        rd_ptr    <= rd_ptr + page_cnt_t'(1);
                    end else if (!alloc_req) begin
                        alloc_ack <= 1'b0;
                    end
                    // Free responder
                    if (free_take) begin
                        free_ack <= 1'b1;
                        wr_ptr   <= wr_ptr + page_cnt_t'(1);
                    end else if (!free_req) begin
                        free_ack <= 1'b0;
                    end
                end
                default: state <= FPL_INIT;
            endcase
            // Count trails the pointers by one cycle
            free_count <= (state == FPL_ACTIVE) ? wr_ptr - rd_ptr : '0;
        end
    end

    //////////////////////////////////////////////////
    // Index storage

    always_ff @(posedge malloc) begin
        if (fifo_we) begin
            fifo[page_idx_t'(wr_ptr)] <= fifo_wdata;
        end
        // Page held stable while ack is high
        if (alloc_take) begin
            alloc_page <= fifo[page_idx_t'(rd_ptr)];
        end
    end

endmodule

// ==== src/pq_enqueue.sv ====
//////////////////////////////////////////////////
// Input side, one page per packet
// Allocates a page, writes each word and commits the descriptor
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pq_macros.svh"

module pq_enqueue (
    input  logic                   malloc,
    input  logic                   rst,
    input  logic                   in_req,
    input  pq_ctrl_pkg::beat_t     in_beat,
    output logic                   in_ack,
    output logic                   alloc_req,
    input  logic                   alloc_ack,
    input  pq_mem_pkg::page_idx_t  alloc_page,
    output logic                   wr_en,
    output pq_mem_pkg::page_idx_t  wr_page,
    output pq_mem_pkg::word_idx_t  wr_word,
    output pq_mem_pkg::data_word_t wr_data,
    output logic                   commit_en,
    output pq_ctrl_pkg::pkt_desc_t commit_desc
);

    import pq_mem_pkg::*;
    import pq_ctrl_pkg::*;

    enq_state_t state;
    page_idx_t  cur_page;
    word_idx_t  word_idx;
    logic       pkt_last;

    //////////////////////////////////////////////////
    // Page store write port

    // Offset advances only after the ack drops
    assign wr_page          = cur_page;
    assign wr_word          = word_idx;
    assign wr_data          = in_beat.data;
    assign commit_desc.page = cur_page;
    assign commit_desc.len  = pkt_len_t'(word_idx) + pkt_len_t'(1);

    //////////////////////////////////////////////////
    // Packet FSM

    always_ff @(posedge malloc) begin
        if (rst) begin
            state     <= ENQ_IDLE;
            in_ack    <= 1'b0;
            alloc_req <= 1'b0;
            wr_en     <= 1'b0;
            commit_en <= 1'b0;
            pkt_last  <= 1'b0;
            cur_page  <= '0;
            word_idx  <= '0;
        end else begin
            // Strobes last one cycle
            wr_en     <= 1'b0;
            commit_en <= 1'b0;
            case (state)
                ENQ_IDLE: begin
                    // First word waits for a page
                    if (in_req && !alloc_ack) begin
                        alloc_req <= 1'b1;
                        state     <= ENQ_ALLOC;
                    end
                end
                ENQ_ALLOC: begin
                    if (alloc_ack) begin
                        alloc_req <= 1'b0;
                        cur_page  <= alloc_page;
                        word_idx  <= '0;
                        state     <= ENQ_WRITE;
                    end
                end
                ENQ_WRITE: begin
                    // Write lands in the cycle in_ack rises
                    if (in_req) begin
                        in_ack    <= 1'b1;
                        wr_en     <= 1'b1;
                        commit_en <= in_beat.last;
                        pkt_last  <= in_beat.last;
                        state     <= ENQ_ACK_WAIT;
                    end
                end
                ENQ_ACK_WAIT: begin
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        if (pkt_last) begin
                            state <= ENQ_IDLE;
                        end else begin
                            word_idx <= word_idx + word_idx_t'(1);
                            state    <= ENQ_WRITE;
                        end
                    end
                end
                default: state <= ENQ_IDLE;
            endcase
        end
    end

endmodule

// ==== src/pq_page_store.sv ====
//////////////////////////////////////////////////
// Page RAM with registered read and the queue of committed packets
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pq_macros.svh"

module pq_page_store (
    input  logic                   malloc,
    input  logic                   rst,
    input  logic                   wr_en,
    input  pq_mem_pkg::page_idx_t  wr_page,
    input  pq_mem_pkg::word_idx_t  wr_word,
    input  pq_mem_pkg::data_word_t wr_data,
    input  logic                   rd_en,
    input  pq_mem_pkg::page_idx_t  rd_page,
    input  pq_mem_pkg::word_idx_t  rd_word,
    output pq_mem_pkg::data_word_t rd_data,
    input  logic                   commit_en,
    input  pq_ctrl_pkg::pkt_desc_t commit_desc,
    input  logic                   pop_en,
    output logic                   desc_valid,
    output pq_ctrl_pkg::pkt_desc_t head_desc
);

    import pq_mem_pkg::*;
    import pq_ctrl_pkg::*;

    //////////////////////////////////////////////////
    // Word RAM

    // Address is page then word offset
    data_word_t ram [`PQ_NUM_PAGES * `PQ_PAGE_WORDS];

    always_ff @(posedge malloc) begin
        if (wr_en) begin
            ram[{wr_page, wr_word}] <= wr_data;
        end
        // Data valid the cycle after rd_en
        if (rd_en) begin
            rd_data <= ram[{rd_page, rd_word}];
        end
    end

    //////////////////////////////////////////////////
    // Descriptor FIFO

    // One slot per page so it never overflows
    pkt_desc_t desc_mem [`PQ_NUM_PAGES];
    page_idx_t head_ptr;
    page_idx_t tail_ptr;
    page_cnt_t desc_cnt;

    always_ff @(posedge malloc) begin
        if (commit_en) begin
            desc_mem[tail_ptr] <= commit_desc;
        end
    end

    always_ff @(posedge malloc) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            desc_cnt <= '0;
        end else begin
            if (commit_en) begin
                tail_ptr <= tail_ptr + page_idx_t'(1);
            end
            if (pop_en) begin
                head_ptr <= head_ptr + page_idx_t'(1);
            end
            // Commit and pop in one cycle cancel out
            case ({commit_en, pop_en})
                2'b10:   desc_cnt <= desc_cnt + page_cnt_t'(1);
                2'b01:   desc_cnt <= desc_cnt - page_cnt_t'(1);
                default: desc_cnt <= desc_cnt;
            endcase
        end
    end

    // Oldest descriptor shown combinationally
    assign head_desc  = desc_mem[head_ptr];
    assign desc_valid = (desc_cnt != '0);

endmodule

// ==== src/pq_dequeue.sv ====
//////////////////////////////////////////////////
// Output side, reads packets in commit order
// Offers each word on four-phase, then frees the page
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pq_macros.svh"

module pq_dequeue (
    input  logic                   malloc,
    input  logic                   rst,
    input  logic                   desc_valid,
    input  pq_ctrl_pkg::pkt_desc_t head_desc,
    output logic                   pop_en,
    output logic                   rd_en,
    output pq_mem_pkg::page_idx_t  rd_page,
    output pq_mem_pkg::word_idx_t  rd_word,
    input  pq_mem_pkg::data_word_t rd_data,
    output logic                   out_req,
    output pq_ctrl_pkg::beat_t     out_beat,
    input  logic                   out_ack,
    output logic                   free_req,
    output pq_mem_pkg::page_idx_t  free_page,
    input  logic                   free_ack
);

    import pq_mem_pkg::*;
    import pq_ctrl_pkg::*;

    deq_state_t state;
    word_idx_t  word_idx;
    logic       rd_wait;
    logic       word_last;

    //////////////////////////////////////////////////
    // RAM read port

    // Read issued on the first READ cycle only
    assign rd_en     = (state == DEQ_READ) && !rd_wait;
    assign rd_page   = head_desc.page;
    assign rd_word   = word_idx;
    assign word_last = (pkt_len_t'(word_idx) + pkt_len_t'(1)) == head_desc.len;

    //////////////////////////////////////////////////
    // Payload registers

    always_ff @(posedge malloc) begin
        if (state == DEQ_READ && rd_wait) begin
            out_beat.data <= rd_data;
            out_beat.last <= word_last;
        end
        // Page kept past the pop
        if (state == DEQ_OFFER && !out_req && !out_ack && word_last) begin
            free_page <= head_desc.page;
        end
    end

    //////////////////////////////////////////////////
    // Packet FSM

    always_ff @(posedge malloc) begin
        if (rst) begin
            state    <= DEQ_IDLE;
            word_idx <= '0;
            rd_wait  <= 1'b0;
            out_req  <= 1'b0;
            pop_en   <= 1'b0;
            free_req <= 1'b0;
        end else begin
            pop_en <= 1'b0;
            case (state)
                DEQ_IDLE: begin
                    if (desc_valid) begin
                        word_idx <= '0;
                        state    <= DEQ_READ;
                    end
                end
                DEQ_READ: begin
                    // Second cycle has rd_data
                    if (!rd_wait) begin
                        rd_wait <= 1'b1;
                    end else begin
                        rd_wait <= 1'b0;
                        out_req <= 1'b1;
                        state   <= DEQ_OFFER;
                    end
                end
                DEQ_OFFER: begin
                    if (out_req && out_ack) begin
                        out_req <= 1'b0;
                    end else if (!out_req && !out_ack) begin
                        // Handshake complete
                        if (word_last) begin
                            pop_en   <= 1'b1;
                            free_req <= 1'b1;
                            state    <= DEQ_FREE;
                        end else begin
                            word_idx <= word_idx + word_idx_t'(1);
                            state    <= DEQ_READ;
                        end
                    end
                end
                DEQ_FREE: begin
                    if (free_ack) begin
                        free_req <= 1'b0;
                        state    <= DEQ_DONE;
                    end
                end
                DEQ_DONE: begin
                    // Wait for the free list to drop its ack
                    if (!free_ack) begin
                        state <= DEQ_IDLE;
                    end
                end
                default: state <= DEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== src/pq_packet_buffer_top.sv ====
//////////////////////////////////////////////////
// Paged packet queue top, four-phase streams in and out
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pq_macros.svh"

module pq_packet_buffer_top (
    input  logic                  malloc,
    input  logic                  rst,
    input  logic                  in_req,
    input  pq_ctrl_pkg::beat_t    in_beat,
    output logic                  in_ack,
    output logic                  out_req,
    output pq_ctrl_pkg::beat_t    out_beat,
    input  logic                  out_ack,
    output pq_mem_pkg::page_cnt_t free_count
);

    import pq_mem_pkg::*;
    import pq_ctrl_pkg::*;

    //////////////////////////////////////////////////
    // Internal nets

    // Allocate and free handshakes
    logic       alloc_req;
    logic       alloc_ack;
    page_idx_t  alloc_page;
    logic       free_req;
    logic       free_ack;
    page_idx_t  free_page;

    // Page store strobes
    logic       wr_en;
    page_idx_t  wr_page;
    word_idx_t  wr_word;
    data_word_t wr_data;
    logic       commit_en;
    pkt_desc_t  commit_desc;
    logic       rd_en;
    page_idx_t  rd_page;
    word_idx_t  rd_word;
    data_word_t rd_data;
    logic       pop_en;
    logic       desc_valid;
    pkt_desc_t  head_desc;

    //////////////////////////////////////////////////
    // Blocks

    pq_free_page_list u_fpl (
        .malloc, .rst,
        .alloc_req, .alloc_ack, .alloc_page,
        .free_req, .free_page, .free_ack,
        .free_count
    );

    pq_enqueue u_enq (
        .malloc, .rst,
        .in_req, .in_beat, .in_ack,
        .alloc_req, .alloc_ack, .alloc_page,
        .wr_en, .wr_page, .wr_word, .wr_data,
        .commit_en, .commit_desc
    );

    pq_page_store u_store (
        .malloc, .rst,
        .wr_en, .wr_page, .wr_word, .wr_data,
        .rd_en, .rd_page, .rd_word, .rd_data,
        .commit_en, .commit_desc,
        .pop_en, .desc_valid, .head_desc
    );

    pq_dequeue u_deq (
        .malloc, .rst,
        .desc_valid, .head_desc, .pop_en,
        .rd_en, .rd_page, .rd_word, .rd_data,
        .out_req, .out_beat, .out_ack,
        .free_req, .free_page, .free_ack
    );

endmodule

// ==== dv/pq_tb_clkgen.sv ====
//////////////////////////////////////////////////
// Free-running testbench clock, 20 ns period
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pq_tb_clkgen #(
    parameter int period_ns = 20
) (
    output logic malloc
);

    localparam int half_ns = period_ns / 2;

    // Starts low so the first rising edge is at half a period
    initial begin
        malloc = 1'b0;
        forever #(half_ns) malloc = ~malloc;
    end

endmodule

// ==== dv/pq_assertions.sv ====
//////////////////////////////////////////////////
// Handshake and packet length assertions
// Bound into the queue top level
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pq_macros.svh"

module pq_assertions (
    input logic               malloc,
    input logic               rst,
    input logic               in_req,
    input pq_ctrl_pkg::beat_t in_beat,
    input logic               in_ack,
    input logic               out_req,
    input pq_ctrl_pkg::beat_t out_beat,
    input logic               out_ack
);

    // Words already offered in the current input packet
    logic req_q;
    int   words_seen;

    always_ff @(posedge malloc) begin
        if (rst) begin
            req_q      <= 1'b0;
            words_seen <= 0;
        end else begin
            req_q <= in_req;
            // New word starts on the req edge
            if (in_req && !req_q) begin
                words_seen <= in_beat.last ? 0 : words_seen + 1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Four-phase rules

    // Data held while req is high
    in_data_stable: assert property (@(posedge malloc) disable iff (rst)
        in_req |=> (!in_req || $stable(in_beat)))
        else $error("Input word changed while in_req was high");

    out_data_stable: assert property (@(posedge malloc) disable iff (rst)
        out_req |=> (!out_req || $stable(out_beat)))
        else $error("Output word changed while out_req was high");

    // New req only once the old ack is gone
    in_req_rise: assert property (@(posedge malloc) disable iff (rst)
        $rose(in_req) |-> !in_ack)
        else $error("in_req rose while in_ack was still high");

    out_req_rise: assert property (@(posedge malloc) disable iff (rst)
        $rose(out_req) |-> !out_ack)
        else $error("out_req rose while out_ack was still high");

    //////////////////////////////////////////////////
    // Packet length

    // Word at the page limit must close the packet
    in_pkt_len: assert property (@(posedge malloc) disable iff (rst)
        (in_req && !req_q) |-> (in_beat.last || words_seen < `PQ_PAGE_WORDS - 1))
        else $error("Input packet is longer than one page");

endmodule

bind pq_packet_buffer_top pq_assertions u_assert (
    .malloc   (malloc),
    .rst      (rst),
    .in_req   (in_req),
    .in_beat  (in_beat),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_beat (out_beat),
    .out_ack  (out_ack)
);

// ==== dv/pq_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the paged packet queue
// Random packets go in and words are checked against a queue model
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pq_macros.svh"

module pq_tb;

    import pq_mem_pkg::*;
    import pq_ctrl_pkg::*;

    localparam int          num_tests   = 5;
    localparam int          cycle_limit = num_tests * 2000;
    localparam logic [31:0] rand_seed   = 32'h94af05ce;

    logic      malloc;
    logic      rst;
    logic      in_req;
    beat_t     in_beat;
    logic      in_ack;
    logic      out_req;
    beat_t     out_beat;
    logic      out_ack;
    page_cnt_t free_count;

    // Words waiting to go in, and words expected out
    beat_t       tx_q [$];
    beat_t       model_q [$];
    int          pkts_queued;
    int          pkts_sent;
    int          pkts_rcvd;
    logic        hold_out;
    int          error_count;
    int          check_count;
    int          errs_at_start;
    int          cycle_count;

    pq_tb_clkgen u_clk (.malloc(malloc));

    pq_packet_buffer_top dut0 (
        .malloc     (malloc),
        .rst        (rst),
        .in_req     (in_req),
        .in_beat    (in_beat),
        .in_ack     (in_ack),
        .out_req    (out_req),
        .out_beat   (out_beat),
        .out_ack    (out_ack),
        .free_count (free_count)
    );

    //////////////////////////////////////////////////
    // Helpers

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("Mismatch at %0d ns: %s, got %0h expected %0h", $time, what, got, want);
        end
    endtask

    // Random data with last on the final word
    task automatic queue_packet(input int len);
        beat_t b;
        for (int i = 0; i < len; i++) begin
            b.data = $urandom();
            b.last = (i == len - 1);
            tx_q.push_back(b);
        end
        pkts_queued++;
    endtask

    // Pages still held equal packets in flight
    task automatic check_free_count(input string what);
        int want;
        want = `PQ_NUM_PAGES - (pkts_sent - pkts_rcvd);
        check_value(what, 64'(free_count), 64'(want));
    endtask

    // Frees trail the last output word by a few cycles
    task automatic wait_drain;
        while (pkts_rcvd != pkts_queued) @(posedge malloc);
        repeat (12) @(posedge malloc);
    endtask

    task automatic apply_reset;
        rst <= 1'b1;
        repeat (10) @(posedge malloc);
        tx_q.delete();
        model_q.delete();
        pkts_queued = 0;
        pkts_sent   = 0;
        pkts_rcvd   = 0;
        hold_out <= 1'b0;
        rst      <= 1'b0;
    endtask

    // Init sweep takes one cycle per page
    task automatic wait_init;
        int waited;
        waited = 0;
        while (free_count != page_cnt_t'(`PQ_NUM_PAGES) && waited < `PQ_NUM_PAGES + 8) begin
            @(posedge malloc);
            check_value("out_req during init", 64'(out_req), 64'd0);
            waited++;
        end
        check_value("free_count after init", 64'(free_count), 64'(`PQ_NUM_PAGES));
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s: %s, %0d errors", num, name,
                 (error_count == errs_at_start) ? "ok" : "errors found",
                 error_count - errs_at_start);
        errs_at_start = error_count;
    endtask

    //////////////////////////////////////////////////
    // Input side with one four-phase transfer per word

    task automatic send_word;
        beat_t b;
        b = tx_q[0];
        in_req  <= 1'b1;
        in_beat <= b;
        do @(posedge malloc); while (!in_ack && !rst);
        in_req <= 1'b0;
        // Word counts only once acked outside reset
        if (!rst) begin
            tx_q.delete(0);
            model_q.push_back(b);
            if (b.last) pkts_sent++;
            do @(posedge malloc); while (in_ack && !rst);
        end
    endtask

    initial begin : input_proc
        in_req  = 1'b0;
        in_beat = '0;
        forever begin
            @(posedge malloc);
            if (rst) begin
                in_req <= 1'b0;
            end else if (tx_q.size() > 0) begin
                repeat ($urandom_range(2, 0)) @(posedge malloc);
                if (!rst && tx_q.size() > 0) send_word();
            end
        end
    end

    //////////////////////////////////////////////////
    // Output side with random ack delay

    task automatic take_word;
        beat_t want;
        while (hold_out && !rst) @(posedge malloc);
        repeat ($urandom_range(3, 0)) @(posedge malloc);
        if (!rst) begin
            if (model_q.size() == 0) begin
                error_count++;
                $display("Output word at %0d ns arrived with nothing sent", $time);
            end else begin
                want = model_q.pop_front();
                check_value("output data", 64'(out_beat.data), 64'(want.data));
                check_value("output last", 64'(out_beat.last), 64'(want.last));
                if (want.last) pkts_rcvd++;
            end
            out_ack <= 1'b1;
            do @(posedge malloc); while (out_req && !rst);
            out_ack <= 1'b0;
        end
    endtask

    initial begin : output_proc
        out_ack = 1'b0;
        forever begin
            @(posedge malloc);
            if (rst) begin
                out_ack <= 1'b0;
            end else if (out_req) begin
                take_word();
            end
        end
    end

    //////////////////////////////////////////////////
    // Watchdog

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge malloc);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////
    // Test sequence

    initial begin : main_seq
        int   base;
        logic saw_ack;
        void'($urandom(rand_seed));
        rst           = 1'b1;
        hold_out      = 1'b0;
        error_count   = 0;
        check_count   = 0;
        errs_at_start = 0;
        apply_reset();
        wait_init();

        // Single 3-word packet
        queue_packet(3);
        wait_drain();
        check_free_count("free_count after one packet");
        end_test(1, "single packet");

        // Forty packets of random length
        for (int i = 0; i < 40; i++) begin
            queue_packet(int'($urandom_range(`PQ_PAGE_WORDS, 1)));
        end
        wait_drain();
        check_free_count("free_count after random packets");
        end_test(2, "random packets");

        // Output stalled until every page is taken
        hold_out <= 1'b1;
        for (int i = 0; i < `PQ_NUM_PAGES; i++) begin
            queue_packet(1);
        end
        while (pkts_sent != pkts_queued) @(posedge malloc);
        repeat (12) @(posedge malloc);
        check_value("free_count with all pages used", 64'(free_count), 64'd0);
        queue_packet(1);
        while (!in_req) @(posedge malloc);
        saw_ack = 1'b0;
        repeat (50) begin
            @(posedge malloc);
            if (in_ack) saw_ack = 1'b1;
        end
        check_value("in_ack with no free page", 64'(saw_ack), 64'd0);
        hold_out <= 1'b0;
        wait_drain();
        check_free_count("free_count after back-pressure");
        end_test(3, "back-pressure");

        // Free count against packets in flight
        hold_out <= 1'b1;
        for (int i = 0; i < 5; i++) begin
            queue_packet(int'($urandom_range(`PQ_PAGE_WORDS, 1)));
        end
        while (pkts_sent != pkts_queued) @(posedge malloc);
        repeat (12) @(posedge malloc);
        check_free_count("free_count with output held");
        hold_out <= 1'b0;
        wait_drain();
        check_free_count("free_count after release");
        end_test(4, "free count");

        // Reset while packets are moving
        for (int i = 0; i < 10; i++) begin
            queue_packet(int'($urandom_range(`PQ_PAGE_WORDS, 1)));
        end
        base = pkts_rcvd;
        while (pkts_rcvd < base + 2) @(posedge malloc);
        repeat ($urandom_range(7, 0)) @(posedge malloc);
        apply_reset();
        wait_init();
        queue_packet(4);
        wait_drain();
        check_free_count("free_count after reset");
        end_test(5, "reset in traffic");

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 num_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+src
src/pq_mem_pkg.sv
src/pq_ctrl_pkg.sv
src/pq_free_page_list.sv
src/pq_enqueue.sv
src/pq_page_store.sv
src/pq_dequeue.sv
src/pq_packet_buffer_top.sv
dv/pq_tb_clkgen.sv
dv/pq_assertions.sv
dv/pq_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the paged packet queue

VERILATOR  ?= verilator
TOP        ?= pq_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= *** TEST PASSED ***
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
